/* hdl/qerv_pkg.sv */
package qerv_pkg;

   localparam int XLEN    = 32;
   localparam int W       = 4;
   localparam int NIBBLES = XLEN / W;
   localparam int REG_AW  = 5;

   localparam logic [XLEN-1:0] RESET_PC = '0;

   // Major opcodes
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

   localparam logic [2:0] F3_ADD = 3'b000;
   localparam logic [2:0] F3_XOR = 3'b100;
   localparam logic [2:0] F3_OR  = 3'b110;
   localparam logic [2:0] F3_AND = 3'b111;

   localparam logic [6:0] F7_ZERO = 7'h00;
   localparam logic [6:0] F7_SUB  = 7'h20;

   // ALU result select
   localparam logic [1:0] SEL_ADD = 2'd0;
   localparam logic [1:0] SEL_XOR = 2'd1;
   localparam logic [1:0] SEL_OR  = 2'd2;
   localparam logic [1:0] SEL_AND = 2'd3;

   // Sequencer states
   localparam logic [1:0] ST_FETCH = 2'd0;
   localparam logic [1:0] ST_REQ   = 2'd1;
   localparam logic [1:0] ST_WAIT  = 2'd2;
   localparam logic [1:0] ST_RUN   = 2'd3;

   typedef logic [W-1:0]      nibble_t;
   typedef logic [REG_AW-1:0] reg_addr_t;
   typedef logic [2:0]        cnt_idx_t;

   typedef struct packed {
      logic [6:0] funct7;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      reg_addr_t  rd;
      logic [6:0] opcode;
   } r_insn_t;

   typedef struct packed {
      logic [11:0] imm12;
      reg_addr_t   rs1;
      logic [2:0]  funct3;
      reg_addr_t   rd;
      logic [6:0]  opcode;
   } i_insn_t;

   // Same word seen as R-type or I-type
   typedef union packed {
      r_insn_t r;
      i_insn_t i;
   } insn_u;

   typedef struct packed {
      logic       sub;
      logic       use_imm;
      logic [1:0] rd_sel;
   } alu_ctrl_t;

   typedef struct packed {
      logic en;
      logic first;
      logic done;
   } cnt_t;

endpackage

/* hdl/qerv_state.sv */
module qerv_state (
   input  logic                      clk,
   input  logic                      i_rst_n,
   input  logic                      i_ibus_ack,
   input  logic                      i_rf_ready,
   input  logic                      i_rd_write,
   output logic                      o_ibus_cyc,
   output logic [qerv_pkg::XLEN-1:0] o_ibus_adr,
   output logic                      o_rf_rreq,
   output logic                      o_wen0,
   output qerv_pkg::cnt_t            o_cnt
);

   import qerv_pkg::*;

   logic [1:0] state;
   logic [1:0] state_nxt;
   cnt_idx_t   cnt_idx;
   logic       run;
   logic       last;

   assign run  = (state == ST_RUN);
   assign last = run && (cnt_idx == cnt_idx_t'(NIBBLES - 1));

   always_comb begin
      state_nxt = state;
      case (state)
         ST_FETCH: begin
            if (i_ibus_ack) begin
               state_nxt = ST_REQ;
            end
         end
         // Decode settles here before the register read
         ST_REQ: begin
            state_nxt = ST_WAIT;
         end
         ST_WAIT: begin
            if (i_rf_ready) begin
               state_nxt = ST_RUN;
            end
         end
         ST_RUN: begin
            if (last) begin
               state_nxt = ST_FETCH;
            end
         end
         default: begin
            state_nxt = ST_FETCH;
         end
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state     <= ST_FETCH;
         cnt_idx   <= '0;
         o_rf_rreq <= 1'b0;
      end else begin
         state <= state_nxt;
         // Pulse lands in the first wait cycle
         o_rf_rreq <= (state == ST_REQ);
         if (run) begin
            cnt_idx <= cnt_idx + cnt_idx_t'(1);
         end
      end
   end

   // PC steps once the last nibble has gone out
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_ibus_adr <= RESET_PC;
      end else if (last) begin
         o_ibus_adr <= o_ibus_adr + XLEN'(4);
      end
   end

   assign o_ibus_cyc = (state == ST_FETCH);
   assign o_wen0     = run && i_rd_write;

   assign o_cnt.en    = run;
   assign o_cnt.first = run && (cnt_idx == '0);
   assign o_cnt.done  = last;

endmodule

/* hdl/qerv_decode.sv */
module qerv_decode (
   input  logic                      clk,
   input  logic                      i_rst_n,
   input  logic [qerv_pkg::XLEN-1:0] i_ibus_rdt,
   input  logic                      i_ibus_ack,
   input  qerv_pkg::cnt_t            i_cnt,
   output qerv_pkg::reg_addr_t       o_rs1,
   output qerv_pkg::reg_addr_t       o_rs2,
   output qerv_pkg::reg_addr_t       o_rd,
   output qerv_pkg::alu_ctrl_t       o_alu_ctrl,
   output qerv_pkg::nibble_t         o_imm,
   output logic                      o_rd_write
);

   import qerv_pkg::*;

   insn_u           rdt;
   insn_u           insn;
   logic [XLEN-1:0] imm_sh;
   logic [6:0]      opcode;
   logic [2:0]      funct3;
   logic [6:0]      funct7;
   logic            is_op;
   logic            is_op_imm;
   logic            f3_kept;
   logic            f7_kept;
   logic            kept;

   assign rdt = i_ibus_rdt;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         insn <= '0;
      end else if (i_ibus_ack) begin
         insn <= rdt;
      end
   end

   // Immediate leaves LSB nibble first
   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         imm_sh <= {{(XLEN - 12){rdt.i.imm12[11]}}, rdt.i.imm12};
      end else if (i_cnt.en) begin
         imm_sh <= {{W{imm_sh[XLEN-1]}}, imm_sh[XLEN-1:W]};
      end
   end

   assign o_imm = imm_sh[W-1:0];

   assign opcode = insn.r.opcode;
   assign funct3 = insn.r.funct3;
   assign funct7 = insn.r.funct7;

   assign is_op     = (opcode == OPC_OP);
   assign is_op_imm = (opcode == OPC_OP_IMM);

   assign f3_kept = (funct3 == F3_ADD) || (funct3 == F3_XOR) ||
                    (funct3 == F3_OR)  || (funct3 == F3_AND);

   // Only ADD may carry the SUB bit
   assign f7_kept = (funct7 == F7_ZERO) ||
                    ((funct7 == F7_SUB) && (funct3 == F3_ADD));

   assign kept = (is_op && f3_kept && f7_kept) || (is_op_imm && f3_kept);

   assign o_rd_write = kept && (insn.r.rd != '0);

   always_comb begin
      o_alu_ctrl.sub     = is_op && funct7[5];
      o_alu_ctrl.use_imm = is_op_imm;
      case (funct3)
         F3_XOR:  o_alu_ctrl.rd_sel = SEL_XOR;
         F3_OR:   o_alu_ctrl.rd_sel = SEL_OR;
         F3_AND:  o_alu_ctrl.rd_sel = SEL_AND;
         default: o_alu_ctrl.rd_sel = SEL_ADD;
      endcase
   end

   assign o_rs1 = insn.r.rs1;
   assign o_rs2 = insn.r.rs2;
   assign o_rd  = insn.r.rd;

endmodule

/* hdl/qerv_alu.sv */
module qerv_alu (
   input  logic                clk,
   input  logic                i_rst_n,
   input  qerv_pkg::cnt_t      i_cnt,
   input  qerv_pkg::alu_ctrl_t i_ctrl,
   input  qerv_pkg::nibble_t   i_rs1,
   input  qerv_pkg::nibble_t   i_rs2,
   input  qerv_pkg::nibble_t   i_imm,
   output qerv_pkg::nibble_t   o_rd
);

   import qerv_pkg::*;

   nibble_t    op_b;
   nibble_t    add_b;
   logic       carry_in;
   logic       carry_q;
   logic [W:0] sum;

   assign op_b  = i_ctrl.use_imm ? i_imm : i_rs2;
   assign add_b = i_ctrl.sub ? ~op_b : op_b;

   // Two's complement plus one enters on the first nibble
   assign carry_in = i_cnt.first ? i_ctrl.sub : carry_q;

   assign sum = {1'b0, i_rs1} + {1'b0, add_b} + {{W{1'b0}}, carry_in};

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carry_q <= 1'b0;
      end else if (i_cnt.en) begin
         carry_q <= sum[W];
      end
   end

   always_comb begin
      case (i_ctrl.rd_sel)
         SEL_XOR: o_rd = i_rs1 ^ op_b;
         SEL_OR:  o_rd = i_rs1 | op_b;
         SEL_AND: o_rd = i_rs1 & op_b;
         default: o_rd = sum[W-1:0];
      endcase
   end

endmodule

/* hdl/qerv_top.sv */
module qerv_top (
   input  logic                      clk,
   input  logic                      i_rst_n,
   // Instruction bus
   output logic [qerv_pkg::XLEN-1:0] o_ibus_adr,
   output logic                      o_ibus_cyc,
   input  logic [qerv_pkg::XLEN-1:0] i_ibus_rdt,
   input  logic                      i_ibus_ack,
   // Register file
   output logic                      o_rf_rreq,
   input  logic                      i_rf_ready,
   output qerv_pkg::reg_addr_t       o_rreg0,
   output qerv_pkg::reg_addr_t       o_rreg1,
   input  qerv_pkg::nibble_t         i_rdata0,
   input  qerv_pkg::nibble_t         i_rdata1,
   output qerv_pkg::reg_addr_t       o_wreg0,
   output logic                      o_wen0,
   output qerv_pkg::nibble_t         o_wdata0
);

   import qerv_pkg::*;

   cnt_t      cnt;
   alu_ctrl_t alu_ctrl;
   nibble_t   imm;
   logic      rd_write;

   qerv_state state_i (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_rf_ready (i_rf_ready),
      .i_rd_write (rd_write),
      .o_ibus_cyc (o_ibus_cyc),
      .o_ibus_adr (o_ibus_adr),
      .o_rf_rreq  (o_rf_rreq),
      .o_wen0     (o_wen0),
      .o_cnt      (cnt)
   );

   qerv_decode decode_i (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .i_cnt      (cnt),
      .o_rs1      (o_rreg0),
      .o_rs2      (o_rreg1),
      .o_rd       (o_wreg0),
      .o_alu_ctrl (alu_ctrl),
      .o_imm      (imm),
      .o_rd_write (rd_write)
   );

   // Result nibble goes straight to the write port
   qerv_alu alu_i (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_cnt   (cnt),
      .i_ctrl  (alu_ctrl),
      .i_rs1   (i_rdata0),
      .i_rs2   (i_rdata1),
      .i_imm   (imm),
      .o_rd    (o_wdata0)
   );

endmodule

/* tests/qerv_tb.sv */
module qerv_tb;

   import qerv_pkg::*;

   localparam int NUM_TESTS = 400;

   logic        clk;
   logic        i_rst_n;
   logic [31:0] i_ibus_rdt;
   logic        i_ibus_ack;
   logic        i_rf_ready;
   nibble_t     i_rdata0;
   nibble_t     i_rdata1;
   logic [31:0] o_ibus_adr;
   logic        o_ibus_cyc;
   logic        o_rf_rreq;
   reg_addr_t   o_rreg0;
   reg_addr_t   o_rreg1;
   reg_addr_t   o_wreg0;
   logic        o_wen0;
   nibble_t     o_wdata0;

   logic [31:0] regs [32];
   logic [31:0] exp_adr;
   integer      seed = 32'h2c1a;
   int          errors = 0;
   int          failed = 0;

   qerv_top dut_i (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_rf_rreq  (o_rf_rreq),
      .i_rf_ready (i_rf_ready),
      .o_rreg0    (o_rreg0),
      .o_rreg1    (o_rreg1),
      .i_rdata0   (i_rdata0),
      .i_rdata1   (i_rdata1),
      .o_wreg0    (o_wreg0),
      .o_wen0     (o_wen0),
      .o_wdata0   (o_wdata0)
   );

   always #4 clk = ~clk;

   task automatic check_hex(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      assert (got === exp) else begin
         $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   function automatic int rand_below(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   // About 80% kept instructions with rd forced to x0 now and then
   function automatic logic [31:0] random_insn();
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [11:0] imm;
      logic [31:0] w;
      rd  = 5'($random(seed));
      rs1 = 5'($random(seed));
      rs2 = 5'($random(seed));
      imm = 12'($random(seed));
      if (rand_below(8) == 0) begin
         rd = '0;
      end
      case (rand_below(9))
         0: w = {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
         1: w = {7'h20, rs2, rs1, 3'b000, rd, 7'b0110011};
         2: w = {7'h00, rs2, rs1, 3'b111, rd, 7'b0110011};
         3: w = {7'h00, rs2, rs1, 3'b110, rd, 7'b0110011};
         4: w = {7'h00, rs2, rs1, 3'b100, rd, 7'b0110011};
         5: w = {imm, rs1, 3'b000, rd, 7'b0010011};
         6: w = {imm, rs1, 3'b111, rd, 7'b0010011};
         7: w = {imm, rs1, 3'b110, rd, 7'b0010011};
         default: w = {imm, rs1, 3'b100, rd, 7'b0010011};
      endcase
      if (rand_below(10) >= 8) begin
         w = 32'($random(seed));
      end
      return w;
   endfunction

   // RV32I semantics of the supported subset
   function automatic logic model_writes(input logic [31:0] w);
      logic f3_ok;
      f3_ok = (w[14:12] == 3'b000) || (w[14:12] == 3'b100) ||
              (w[14:12] == 3'b110) || (w[14:12] == 3'b111);
      if (w[11:7] == 5'd0) begin
         return 1'b0;
      end
      if (w[6:0] == 7'b0010011) begin
         return f3_ok;
      end
      if (w[6:0] == 7'b0110011) begin
         return f3_ok && ((w[31:25] == 7'h00) ||
                          (w[31:25] == 7'h20 && w[14:12] == 3'b000));
      end
      return 1'b0;
   endfunction

   function automatic logic [31:0] model_result(input logic [31:0] w, input logic [31:0] a,
                                                input logic [31:0] b);
      logic [31:0] opb;
      opb = (w[6:0] == 7'b0010011) ? {{20{w[31]}}, w[31:20]} : b;
      case (w[14:12])
         3'b100:  return a ^ opb;
         3'b110:  return a | opb;
         3'b111:  return a & opb;
         default: return (w[6:0] == 7'b0110011 && w[30]) ? a - opb : a + opb;
      endcase
   endfunction

   task automatic run_insn(input int t);
      logic [31:0] word;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] exp_res;
      logic [31:0] got_res;
      logic        wr;
      int          d;
      int          k;
      int          wen_cnt;
      int          err0;
      err0    = errors;
      wen_cnt = 0;
      got_res = '0;
      word    = random_insn();
      d       = rand_below(4);
      for (k = 0; k <= d; k++) begin
         if (k > 0) begin
            @(posedge clk);
         end
         if (k == d) begin
            i_ibus_ack <= 1'b1;
            i_ibus_rdt <= word;
         end
         @(negedge clk);
         check_hex("o_ibus_cyc", 32'(o_ibus_cyc), 32'd1);
         check_hex("o_ibus_adr", o_ibus_adr, exp_adr);
         check_hex("o_rf_rreq", 32'(o_rf_rreq), 32'd0);
         if (o_wen0) begin
            wen_cnt++;
         end
      end
      @(posedge clk);
      i_ibus_ack <= 1'b0;
      a       = regs[word[19:15]];
      b       = regs[word[24:20]];
      wr      = model_writes(word);
      exp_res = model_result(word, a, b);
      @(negedge clk);
      check_hex("o_rf_rreq", 32'(o_rf_rreq), 32'd0);
      check_hex("o_ibus_cyc", 32'(o_ibus_cyc), 32'd0);
      if (o_wen0) begin
         wen_cnt++;
      end
      // Ready may come in the rreq cycle itself
      d = rand_below(4);
      for (k = 0; k <= d; k++) begin
         @(posedge clk);
         if (k == d) begin
            i_rf_ready <= 1'b1;
         end
         @(negedge clk);
         check_hex("o_rf_rreq", 32'(o_rf_rreq), 32'(k == 0));
         check_hex("o_rreg0", 32'(o_rreg0), 32'(word[19:15]));
         check_hex("o_rreg1", 32'(o_rreg1), 32'(word[24:20]));
         check_hex("o_wen0", 32'(o_wen0), 32'd0);
      end
      for (k = 0; k < NIBBLES; k++) begin
         @(posedge clk);
         i_rf_ready <= 1'b0;
         i_rdata0   <= a[4*k +: 4];
         i_rdata1   <= b[4*k +: 4];
         @(negedge clk);
         check_hex("o_wen0", 32'(o_wen0), 32'(wr));
         check_hex("o_rreg0", 32'(o_rreg0), 32'(word[19:15]));
         check_hex("o_rreg1", 32'(o_rreg1), 32'(word[24:20]));
         if (o_wen0) begin
            wen_cnt++;
            got_res[4*k +: 4] = o_wdata0;
            check_hex("o_wreg0", 32'(o_wreg0), 32'(word[11:7]));
         end
      end
      @(posedge clk);
      i_rdata0 <= '0;
      i_rdata1 <= '0;
      assert (wen_cnt == (wr ? NIBBLES : 0)) else begin
         $display("Instruction %0d gave %0d write cycles instead of %0d", t, wen_cnt,
                  wr ? NIBBLES : 0);
         errors++;
      end
      if (wr) begin
         check_hex("o_wdata0", got_res, exp_res);
         regs[word[11:7]] = exp_res;
      end
      exp_adr = exp_adr + 32'd4;
      if (errors != err0) begin
         failed++;
      end
      $display("test %0d insn 0x%08h write %0d: %s", t, word, wr,
               (errors == err0) ? "ok" : "FAILED");
   endtask

   initial begin
      clk        = 1'b0;
      i_rst_n    = 1'b0;
      i_ibus_rdt = '0;
      i_ibus_ack = 1'b0;
      i_rf_ready = 1'b0;
      i_rdata0   = '0;
      i_rdata1   = '0;
      regs[0]    = '0;
      for (int i = 1; i < 32; i++) begin
         regs[i] = 32'($random(seed));
      end
      repeat (16) begin
         @(negedge clk);
         check_hex("o_rf_rreq", 32'(o_rf_rreq), 32'd0);
         check_hex("o_wen0", 32'(o_wen0), 32'd0);
         check_hex("o_ibus_cyc", 32'(o_ibus_cyc), 32'd1);
         check_hex("o_ibus_adr", o_ibus_adr, 32'd0);
      end
      @(posedge clk);
      i_rst_n <= 1'b1;
      exp_adr = '0;
      for (int t = 0; t < NUM_TESTS; t++) begin
         run_insn(t);
      end
      $display("Tests run: %0d, failed: %0d, error lines: %0d", NUM_TESTS, failed, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   // Up to 30 cycles per instruction
   initial begin
      #(NUM_TESTS * 30 * 8);
      $display("Timeout: the core stopped making progress");
      $display("Some tests failed");
      $finish;
   end

endmodule

/* qerv_top.f */
hdl/qerv_pkg.sv
hdl/qerv_state.sv
hdl/qerv_decode.sv
hdl/qerv_alu.sv
hdl/qerv_top.sv
tests/qerv_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the qerv testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module qerv_tb -f qerv_top.f -o qerv_sim &&
./obj_dir/qerv_sim | tee /dev/stderr | grep -q "All tests passed" &&
echo "SIMULATION PASSED" ||
{ echo "SIMULATION FAILED"; exit 1; }
